// File: src/keypad_pkg.sv
/*
  keypad matrix package
  matrix size, scan timing default and the sixteen key codes
*/
`default_nettype none

package keypad_pkg;

  // rows and columns of the matrix
  localparam int unsigned MATRIX_LINES = 4;

  // clock cycles per column step
  localparam int unsigned SCAN_DIV = 5000;

  // upper nibble is the one-hot row, lower nibble the one-hot column
  typedef enum logic [7:0] {
    KEY_1    = 8'b0001_0001,
    KEY_2    = 8'b0001_0010,
    KEY_3    = 8'b0001_0100,
    KEY_A    = 8'b0001_1000,
    KEY_4    = 8'b0010_0001,
    KEY_5    = 8'b0010_0010,
    KEY_6    = 8'b0010_0100,
    KEY_B    = 8'b0010_1000,
    KEY_7    = 8'b0100_0001,
    KEY_8    = 8'b0100_0010,
    KEY_9    = 8'b0100_0100,
    KEY_C    = 8'b0100_1000,
    KEY_STAR = 8'b1000_0001,
    KEY_0    = 8'b1000_0010,
    KEY_HASH = 8'b1000_0100,
    KEY_D    = 8'b1000_1000
  } key_t;

  // strobe is high for one cycle per new press
  typedef struct packed {
    logic strobe;
    key_t code;
  } key_event_t;

endpackage

`default_nettype wire

// File: src/text_pkg.sv
/*
  text entry package
  characters, the edit line, entry mode and the tap and edit records
*/
`default_nettype none

package text_pkg;

  // characters on the line
  localparam int unsigned LINE_CHARS = 16;

  localparam logic [7:0] SPACE_CHAR = 8'h20;

  typedef logic [7:0] char_t;

  // index 0 is the rightmost, newest position
  typedef char_t [LINE_CHARS-1:0] line_t;

  // empty line, used at reset and after a send
  localparam line_t BLANK_LINE = {LINE_CHARS{SPACE_CHAR}};

  typedef enum logic {
    MODE_NUMBER,
    MODE_LETTER
  } mode_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_GLYPH,
    OP_CONFIRM,
    OP_BACK,
    OP_SEND
  } edit_op_t;

  // one classified key press
  typedef struct packed {
    logic             valid;
    edit_op_t         op;
    keypad_pkg::key_t key;
    logic [1:0]       count;
    mode_t            mode;
    logic             upper;
  } tap_t;

  // decoded edit for the line register
  typedef struct packed {
    logic     valid;
    edit_op_t op;
    char_t    glyph;
    logic     glyph_ok;
  } edit_t;

endpackage

`default_nettype wire

// File: src/keypad_scanner.sv
/*
  keypad matrix scanner
  walks an active-low column strobe, synchronizes the row lines and
  emits one key event per new press
*/
`default_nettype none

module keypad_scanner #(
  // must be 3 or more so the rows settle before the next step
  parameter int unsigned scan_div = keypad_pkg::SCAN_DIV
) (
  input  logic                                clk,
  input  logic                                nrst,
  input  logic [keypad_pkg::MATRIX_LINES-1:0] row,
  output logic [keypad_pkg::MATRIX_LINES-1:0] col_n,
  output keypad_pkg::key_event_t              key_event
);
  import keypad_pkg::*;

  logic [$clog2(scan_div)-1:0] div_cnt;
  logic [MATRIX_LINES-1:0]     row_meta;
  logic [MATRIX_LINES-1:0]     row_sync;
  logic [MATRIX_LINES-1:0]     col_d1;
  logic [MATRIX_LINES-1:0]     col_d2;
  logic                        any_row;
  logic                        any_row_q;
  logic                        step;
  logic                        rise;
  logic                        aligned;
  logic                        strobe_q;
  logic [2*MATRIX_LINES-1:0]   code_q;

  assign any_row = |row_sync;
  assign rise    = any_row & ~any_row_q;
  // column only moves when no key is seen
  assign step    = (div_cnt == $bits(div_cnt)'(scan_div - 1)) & ~any_row;
  // rows in the sync flops belong to the column still driven
  assign aligned = (col_d2 == col_n);

  // two-flop row synchronizer
  // column delayed by the same two cycles
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      row_meta  <= '0;
      row_sync  <= '0;
      col_d1    <= '1;
      col_d2    <= '1;
      any_row_q <= 1'b0;
    end else begin
      row_meta  <= row;
      row_sync  <= row_meta;
      col_d1    <= col_n;
      col_d2    <= col_d1;
      any_row_q <= any_row;
    end
  end

  // free running divider and column rotation
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      div_cnt <= '0;
      col_n   <= '1;
    end else begin
      if (div_cnt == $bits(div_cnt)'(scan_div - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (step) begin
        // all ones only after reset, then rotate the single low bit
        if (&col_n) begin
          col_n <= {{(MATRIX_LINES-1){1'b1}}, 1'b0};
        end else begin
          col_n <= {col_n[MATRIX_LINES-2:0], col_n[MATRIX_LINES-1]};
        end
      end
    end
  end

  // press strobe and key code
  // a rise seen after the column moved on is dropped, the key is
  // caught again when the scan comes back to it
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      strobe_q <= 1'b0;
      code_q   <= '0;
    end else begin
      strobe_q <= rise & aligned;
      if (rise && aligned) begin
        code_q <= {row_sync, ~col_n};
      end else if (!any_row) begin
        // released
        code_q <= '0;
      end
    end
  end

  assign key_event.strobe = strobe_q;
  assign key_event.code   = key_t'(code_q);

endmodule

`default_nettype wire

// File: src/multitap_control.sv
/*
  multi-tap press classifier
  tracks previous key, repeat count, mode and shift, and turns each
  press into a registered tap record
*/
`default_nettype none

module multitap_control (
  input  logic                   clk,
  input  logic                   nrst,
  input  keypad_pkg::key_event_t key_event,
  output text_pkg::tap_t         tap
);
  import keypad_pkg::*;
  import text_pkg::*;

  key_t       prev_key;
  logic [1:0] count_q;
  logic [1:0] count_d;
  mode_t      mode_q;
  mode_t      mode_d;
  logic       upper_q;
  logic       upper_d;
  edit_op_t   op_d;

  always_comb begin
    count_d = count_q;
    mode_d  = mode_q;
    upper_d = upper_q;
    op_d    = OP_NONE;
    case (key_event.code)
      KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9, KEY_STAR: begin
        op_d = OP_GLYPH;
        // same key again walks through its glyphs, wraps after four
        count_d = (key_event.code == prev_key) ? count_q + 2'd1 : 2'd0;
      end
      KEY_B: mode_d = (mode_q == MODE_NUMBER) ? MODE_LETTER : MODE_NUMBER;
      KEY_HASH: upper_d = ~upper_q;
      KEY_C: begin
        op_d    = OP_CONFIRM;
        count_d = 2'd0;
      end
      KEY_A: begin
        op_d    = OP_BACK;
        count_d = 2'd0;
      end
      KEY_D: begin
        op_d    = OP_SEND;
        count_d = 2'd0;
      end
      default: op_d = OP_NONE;
    endcase
  end

  // state moves only on a press strobe, so held keys toggle once
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      prev_key <= key_t'(8'h00);
      count_q  <= 2'd0;
      mode_q   <= MODE_NUMBER;
      upper_q  <= 1'b0;
      tap      <= '0;
    end else if (key_event.strobe) begin
      prev_key <= key_event.code;
      count_q  <= count_d;
      mode_q   <= mode_d;
      upper_q  <= upper_d;
      tap      <= '{valid: 1'b1, op: op_d, key: key_event.code, count: count_d,
                    mode: mode_q, upper: upper_q};
    end else begin
      tap.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/char_decode.sv
/*
  multi-tap character decoder
  combinational lookup from a glyph tap to its ASCII character
*/
`default_nettype none

module char_decode (
  input  text_pkg::tap_t  tap,
  output text_pkg::edit_t edit
);
  import keypad_pkg::*;
  import text_pkg::*;

  // digit, four tap glyphs (count 0 in the top byte), glyph count, letter flag
  logic [8+32+3+1-1:0] entry;
  char_t               digit;
  logic [31:0]         tap_set;
  logic [2:0]          tap_len;
  logic                is_alpha;
  char_t               letter;

  always_comb begin
    case (tap.key)
      KEY_1:    entry = {"1", "@_&:", 3'd4, 1'b0};
      KEY_2:    entry = {"2", "abc ", 3'd3, 1'b1};
      KEY_3:    entry = {"3", "def ", 3'd3, 1'b1};
      KEY_4:    entry = {"4", "ghi ", 3'd3, 1'b1};
      KEY_5:    entry = {"5", "jkl ", 3'd3, 1'b1};
      KEY_6:    entry = {"6", "mno ", 3'd3, 1'b1};
      KEY_7:    entry = {"7", "pqrs", 3'd4, 1'b1};
      KEY_8:    entry = {"8", "tuv ", 3'd3, 1'b1};
      KEY_9:    entry = {"9", "wxyz", 3'd4, 1'b1};
      KEY_STAR: entry = {"*", "+-/=", 3'd4, 1'b0};
      KEY_0:    entry = {"0", ",.?!", 3'd4, 1'b0};
      // control keys carry no glyphs
      default:  entry = {SPACE_CHAR, {4{SPACE_CHAR}}, 3'd0, 1'b0};
    endcase
  end

  assign {digit, tap_set, tap_len, is_alpha} = entry;

  // pick the glyph for this repeat count
  assign letter = tap_set[8*(3 - tap.count) +: 8];

  always_comb begin
    edit.valid    = tap.valid;
    edit.op       = tap.op;
    edit.glyph    = SPACE_CHAR;
    edit.glyph_ok = 1'b0;
    if (tap.op == OP_GLYPH && tap_len != 3'd0) begin
      if (tap.mode == MODE_NUMBER) begin
        edit.glyph    = digit;
        edit.glyph_ok = 1'b1;
      end else if ({1'b0, tap.count} < tap_len) begin
        // clearing bit 5 gives the capital, symbols stay as they are
        edit.glyph    = (is_alpha && tap.upper) ? (letter & ~8'h20) : letter;
        edit.glyph_ok = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/text_line_editor.sv
/*
  text line editor
  applies edits to the 16 character line and hands a finished line
  to the consumer over a four-phase req/ack handshake
*/
`default_nettype none

module text_line_editor (
  input  logic            clk,
  input  logic            nrst,
  input  text_pkg::edit_t edit,
  input  logic            send_ack,
  output text_pkg::line_t line,
  output text_pkg::line_t sent_line,
  output logic            send_req
);
  import text_pkg::*;

  logic hs_idle;

  // previous transfer fully closed, ack seen low again
  assign hs_idle = ~send_req & ~send_ack;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      line      <= BLANK_LINE;
      sent_line <= BLANK_LINE;
      send_req  <= 1'b0;
    end else begin
      // consumer took the line, release the request
      if (send_req && send_ack) begin
        send_req <= 1'b0;
      end
      if (edit.valid) begin
        case (edit.op)
          OP_GLYPH: begin
            // count past the key's glyphs leaves the line alone
            if (edit.glyph_ok) begin
              line[0] <= edit.glyph;
            end
          end
          OP_CONFIRM: begin
            // move text left, fresh slot at the right end
            line <= {line[LINE_CHARS-2:0], SPACE_CHAR};
          end
          OP_BACK: begin
            // drop the rightmost char, space enters at the left
            line <= {SPACE_CHAR, line[LINE_CHARS-1:1]};
          end
          OP_SEND: begin
            // busy handshake ignores the press and keeps the text
            if (hs_idle) begin
              sent_line <= line;
              send_req  <= 1'b1;
              line      <= BLANK_LINE;
            end
          end
          default: line <= line;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/keypad_text_top.sv
/*
  keypad text entry top level
  scanner, multi-tap classifier, character decoder and line editor
*/
`default_nettype none

module keypad_text_top #(
  parameter int unsigned scan_div = keypad_pkg::SCAN_DIV
) (
  input  logic                                clk,
  input  logic                                nrst,
  input  logic [keypad_pkg::MATRIX_LINES-1:0] row,
  input  logic                                send_ack,
  output logic [keypad_pkg::MATRIX_LINES-1:0] col_n,
  output text_pkg::line_t                     line,
  output text_pkg::line_t                     sent_line,
  output logic                                send_req
);
  import keypad_pkg::*;
  import text_pkg::*;

  key_event_t key_event;
  tap_t       tap;
  edit_t      edit;

  // press strobe to line update is two cycles
  keypad_scanner #(
    .scan_div (scan_div)
  ) u_scanner (
    .clk       (clk),
    .nrst      (nrst),
    .row       (row),
    .col_n     (col_n),
    .key_event (key_event)
  );

  multitap_control u_multitap (
    .clk       (clk),
    .nrst      (nrst),
    .key_event (key_event),
    .tap       (tap)
  );

  char_decode u_decode (
    .tap  (tap),
    .edit (edit)
  );

  text_line_editor u_editor (
    .clk       (clk),
    .nrst      (nrst),
    .edit      (edit),
    .send_ack  (send_ack),
    .line      (line),
    .sent_line (sent_line),
    .send_req  (send_req)
  );

endmodule

`default_nettype wire

// File: verification/keypad_text_sva.sv
/*
  keypad text entry assertions
  column strobe shape, press strobe width and send handshake order
*/
`default_nettype none

module keypad_text_sva (
  input logic                   clk,
  input logic                   nrst,
  input logic [3:0]             col_n,
  input keypad_pkg::key_event_t key_event,
  input logic                   send_req,
  input logic                   send_ack
);

  // never two columns driven at once
  assert property (@(posedge clk) disable iff (!nrst) $countones(~col_n) <= 1)
    else $error("more than one column driven low");

  // one pulse per press
  assert property (@(posedge clk) disable iff (!nrst) key_event.strobe |=> !key_event.strobe)
    else $error("press strobe longer than one cycle");

  // req drops only after ack was seen
  assert property (@(posedge clk) disable iff (!nrst) $fell(send_req) |-> $past(send_ack))
    else $error("send_req dropped without send_ack");

  // new req only once ack is low again
  assert property (@(posedge clk) disable iff (!nrst) $rose(send_req) |-> !$past(send_ack))
    else $error("send_req raised while send_ack high");

endmodule

bind keypad_text_top keypad_text_sva u_sva (
  .clk       (clk),
  .nrst      (nrst),
  .col_n     (col_n),
  .key_event (key_event),
  .send_req  (send_req),
  .send_ack  (send_ack)
);

`default_nettype wire

// File: verification/tb_keypad_text.sv
/*
  testbench for the keypad text entry top level
  keypad matrix model, four-phase consumer, stimulus table and timeout
*/
`default_nettype none

module tb_keypad_text;
  import keypad_pkg::*;
  import text_pkg::*;

  // cycles a key stays down, then idle cycles after release
  localparam int HOLD = 40;
  localparam int GAP  = 8;

  logic                    clk;
  logic                    nrst;
  logic [MATRIX_LINES-1:0] row;
  logic                    send_ack;
  logic [MATRIX_LINES-1:0] col_n;
  line_t                   line;
  line_t                   sent_line;
  logic                    send_req;

  // keypad model state
  key_t pressed;
  logic key_down;

  // stimulus table, one key and the line expected after it
  key_t  step_key[$];
  line_t step_line[$];

  integer seed = 51079;
  int     checks;
  int     errors;
  int     cycles;
  int     max_cycles;

  keypad_text_top #(
    .scan_div (4)
  ) uut (
    .clk       (clk),
    .nrst      (nrst),
    .row       (row),
    .send_ack  (send_ack),
    .col_n     (col_n),
    .line      (line),
    .sent_line (sent_line),
    .send_req  (send_req)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // row bit of the held key shows only while its column is strobed low
  always @(negedge clk) begin
    if (key_down && ((~col_n & pressed[3:0]) != '0)) begin
      row <= pressed[7:4];
    end else begin
      row <= '0;
    end
  end

  // consumer, slow ack so a second send lands while busy
  initial begin : consumer
    int delay;
    forever begin
      @(negedge clk);
      if (send_req && !send_ack) begin
        delay = 250 + ($random(seed) & 63);
        repeat (delay) @(negedge clk);
        send_ack = 1'b1;
        while (send_req) @(negedge clk);
        send_ack = 1'b0;
      end
    end
  end

  // text laid out from the right end, spaces to the left
  function automatic line_t right_aligned(input string s);
    line_t l;
    l = BLANK_LINE;
    for (int i = 0; i < s.len(); i++) begin
      l[i] = s[s.len() - 1 - i];
    end
    return l;
  endfunction

  task automatic add_step(input key_t k, input string s);
    step_key.push_back(k);
    step_line.push_back(right_aligned(s));
  endtask

  // press, hold, release, then let the line settle
  task automatic apply_key(input key_t k);
    pressed  <= k;
    key_down <= 1'b1;
    repeat (HOLD) @(negedge clk);
    key_down <= 1'b0;
    repeat (GAP) @(negedge clk);
  endtask

  task automatic check_line(input line_t got, input line_t want, input string what);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("FAIL %0t: %s is \"%s\", expected \"%s\"", $time, what, got, want);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic build_table();
    // number mode
    add_step(KEY_4, "4");
    add_step(KEY_C, "4 ");
    add_step(KEY_2, "42");
    add_step(KEY_C, "42 ");
    // letter mode, 7 three times
    add_step(KEY_B, "42 ");
    add_step(KEY_7, "42p");
    add_step(KEY_7, "42q");
    add_step(KEY_7, "42r");
    add_step(KEY_C, "42r ");
    // fourth tap on 2 is past its letters
    add_step(KEY_2, "42ra");
    add_step(KEY_2, "42rb");
    add_step(KEY_2, "42rc");
    add_step(KEY_2, "42rc");
    add_step(KEY_C, "42rc ");
    // shift
    add_step(KEY_HASH, "42rc ");
    add_step(KEY_9, "42rcW");
    add_step(KEY_C, "42rcW ");
    // symbols ignore shift, '&' has bit 5 set
    add_step(KEY_1, "42rcW@");
    add_step(KEY_1, "42rcW_");
    add_step(KEY_1, "42rcW&");
    add_step(KEY_A, "42rcW");
    // send, then type and send again while busy
    add_step(KEY_D, "");
    add_step(KEY_B, "");
    add_step(KEY_5, "5");
    add_step(KEY_D, "5");
  endtask

  initial begin : watchdog
    @(posedge clk);
    // one extra press after the table
    max_cycles = (step_key.size() + 1) * (HOLD + GAP) * 2;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("test timed out after %0d cycles, %0d errors so far", cycles, errors);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    nrst     = 1'b0;
    row      = '0;
    send_ack = 1'b0;
    pressed  = KEY_1;
    key_down = 1'b0;
    checks   = 0;
    errors   = 0;
    cycles   = 0;
    build_table();
    repeat (8) @(negedge clk);
    nrst = 1'b1;
    @(negedge clk);
    check_line(line, BLANK_LINE, "line after reset");
    check_line(sent_line, BLANK_LINE, "sent_line after reset");
    check_flag(send_req, 1'b0, "send_req after reset");
    // no column driven before the first divider step
    check_flag(&col_n, 1'b1, "col_n all high after reset");

    foreach (step_key[i]) begin
      apply_key(step_key[i]);
      check_line(line, step_line[i], $sformatf("line after step %0d", i));
    end
    // busy send kept the first line
    check_line(sent_line, right_aligned("42rcW"), "sent_line after busy send");
    check_flag(send_req, 1'b1, "send_req while waiting for ack");

    // handshake closes, then a new send goes through
    while (send_req || send_ack) @(negedge clk);
    apply_key(KEY_D);
    check_line(sent_line, right_aligned("5"), "sent_line after second send");
    check_line(line, BLANK_LINE, "line after second send");
    check_flag(send_req, 1'b1, "send_req after second send");

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/keypad_pkg.sv
src/text_pkg.sv
src/keypad_scanner.sv
src/multitap_control.sv
src/char_decode.sv
src/text_line_editor.sv
src/keypad_text_top.sv
verification/keypad_text_sva.sv
verification/tb_keypad_text.sv

// File: Bender.yml
package:
  name: keypad_text

sources:
  - src/keypad_pkg.sv
  - src/text_pkg.sv
  - src/keypad_scanner.sv
  - src/multitap_control.sv
  - src/char_decode.sv
  - src/text_line_editor.sv
  - src/keypad_text_top.sv
  - target: test
    files:
      - verification/keypad_text_sva.sv
      - verification/tb_keypad_text.sv
